// File: verilog/decoder_defines.svh
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

`define DEC_WORD_W      32
`define DEC_REG_W       5
`define DEC_OP_W        6
`define DEC_IMM_W       16
`define DEC_IDX_W       26
`define DEC_LINK_REG    5'd31
`define DEC_LINK_OFFSET 32'd8

// major opcodes
`define DEC_OP_SPECIAL  6'b00_0000
`define DEC_OP_REGIMM   6'b00_0001
`define DEC_OP_J        6'b00_0010
`define DEC_OP_JAL      6'b00_0011
`define DEC_OP_BEQ      6'b00_0100
`define DEC_OP_BNE      6'b00_0101
`define DEC_OP_BLEZ     6'b00_0110
`define DEC_OP_BGTZ     6'b00_0111
`define DEC_OP_ADDI     6'b00_1000
`define DEC_OP_ADDIU    6'b00_1001
`define DEC_OP_SLTI     6'b00_1010
`define DEC_OP_SLTIU    6'b00_1011
`define DEC_OP_ANDI     6'b00_1100
`define DEC_OP_ORI      6'b00_1101
`define DEC_OP_XORI     6'b00_1110
`define DEC_OP_LUI      6'b00_1111
`define DEC_OP_COP0     6'b01_0000
`define DEC_OP_LB       6'b10_0000
`define DEC_OP_LH       6'b10_0001
`define DEC_OP_LW       6'b10_0011
`define DEC_OP_LBU      6'b10_0100
`define DEC_OP_LHU      6'b10_0101
`define DEC_OP_SB       6'b10_1000
`define DEC_OP_SH       6'b10_1001
`define DEC_OP_SW       6'b10_1011

// SPECIAL funct, plus eret under COP0
`define DEC_FN_SLL      6'b00_0000
`define DEC_FN_SRL      6'b00_0010
`define DEC_FN_SRA      6'b00_0011
`define DEC_FN_SLLV     6'b00_0100
`define DEC_FN_SRLV     6'b00_0110
`define DEC_FN_SRAV     6'b00_0111
`define DEC_FN_JR       6'b00_1000
`define DEC_FN_JALR     6'b00_1001
`define DEC_FN_SYSCALL  6'b00_1100
`define DEC_FN_BREAK    6'b00_1101
`define DEC_FN_ERET     6'b01_1000
`define DEC_FN_ADD      6'b10_0000
`define DEC_FN_ADDU     6'b10_0001
`define DEC_FN_SUB      6'b10_0010
`define DEC_FN_SUBU     6'b10_0011
`define DEC_FN_AND      6'b10_0100
`define DEC_FN_OR       6'b10_0101
`define DEC_FN_XOR      6'b10_0110
`define DEC_FN_NOR      6'b10_0111
`define DEC_FN_SLT      6'b10_1010
`define DEC_FN_SLTU     6'b10_1011

// REGIMM rt codes and COP0 rs codes
`define DEC_RT_BLTZ     5'b0_0000
`define DEC_RT_BGEZ     5'b0_0001
`define DEC_RT_BLTZAL   5'b1_0000
`define DEC_RT_BGEZAL   5'b1_0001
`define DEC_RS_MFC0     5'b0_0000
`define DEC_RS_MTC0     5'b0_0100

`endif

// File: verilog/isa_pkg.sv
`include "decoder_defines.svh"

package isa_pkg;

    typedef struct packed {
        logic [`DEC_OP_W-1:0]  opcode;
        logic [`DEC_REG_W-1:0] rs;
        logic [`DEC_REG_W-1:0] rt;
        logic [`DEC_REG_W-1:0] rd;
        logic [`DEC_REG_W-1:0] sa;
        logic [`DEC_OP_W-1:0]  funct;
    } r_view_t;

    typedef struct packed {
        logic [`DEC_OP_W-1:0]  opcode;
        logic [`DEC_REG_W-1:0] rs;
        logic [`DEC_REG_W-1:0] rt;
        logic [`DEC_IMM_W-1:0] imm;
    } i_view_t;

    typedef struct packed {
        logic [`DEC_OP_W-1:0]  opcode;
        logic [`DEC_IDX_W-1:0] index;
    } j_view_t;

    typedef union packed {
        logic [`DEC_WORD_W-1:0] word;
        r_view_t                r;
        i_view_t                i;
        j_view_t                j;
    } inst_word_t;

    // one flag per supported instruction
    typedef struct packed {
        logic add, addu, sub, subu, slt, sltu;
        logic and_r, nor_r, or_r, xor_r;
        logic sll, srl, sra, sllv, srlv, srav;
        logic addi, addiu, slti, sltiu, andi, ori, xori, lui;
        logic beq, bne, bgez, bgtz, blez, bltz, bgezal, bltzal;
        logic j, jal, jr, jalr;
        logic lb, lbu, lh, lhu, lw, sb, sh, sw;
        logic syscall, brk, eret, mfc0, mtc0;
    } inst_set_t;

endpackage

// File: verilog/ctrl_pkg.sv
`include "decoder_defines.svh"

package ctrl_pkg;

    typedef struct packed {
        logic op_add, op_sub, op_slt, op_sltu;
        logic op_and, op_nor, op_or, op_xor;
        logic op_sll, op_srl, op_sra, op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;
        logic pc;
        logic rs;
    } src1_sel_t;

    typedef struct packed {
        logic zimm;
        logic link;
        logic simm;
        logic rt;
    } src2_sel_t;

    typedef struct packed {
        logic lb, lbu, lh, lhu, lw;
        logic sb, sh, sw;
    } mem_op_t;

    typedef struct packed {
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        mem_op_t               mem_op;
        logic                  mem_en;
        logic                  mem_wen;
        logic                  rf_we;
        logic [`DEC_REG_W-1:0] rf_waddr;
        logic                  rf_from_load;
    } id_ctrl_t;

    typedef struct packed {
        logic                   br_taken;
        logic [`DEC_WORD_W-1:0] br_target;
    } br_bus_t;

    typedef struct packed {
        logic [`DEC_REG_W-1:0] cp0_sel;
        logic                  delay_slot;
        logic                  pc_misaligned;
        logic                  syscall;
        logic                  brk;
        logic                  invalid;
        logic                  eret;
        logic                  mfc0;
        logic                  mtc0;
    } except_t;

    // what execute is about to write back
    typedef struct packed {
        logic                  rf_we;
        logic [`DEC_REG_W-1:0] rf_waddr;
        logic                  is_mfc0;
    } ex_fwd_t;

endpackage

// File: verilog/inst_match.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module inst_match import isa_pkg::*; (
    input  inst_word_t inst,
    output inst_set_t  inst_set
);

    logic special, regimm, cop0;
    logic rs_zero, rt_zero, rd_zero, sa_zero;
    logic r3, shi;
    logic [`DEC_OP_W-1:0] fn;

    assign special = (inst.r.opcode == `DEC_OP_SPECIAL);
    assign regimm  = (inst.i.opcode == `DEC_OP_REGIMM);
    assign cop0    = (inst.r.opcode == `DEC_OP_COP0);
    assign rs_zero = (inst.r.rs == '0);
    assign rt_zero = (inst.r.rt == '0);
    assign rd_zero = (inst.r.rd == '0);
    assign sa_zero = (inst.r.sa == '0);
    assign fn      = inst.r.funct;

    // register alu and variable shifts need sa zero, constant shifts need rs zero
    assign r3  = special & sa_zero;
    assign shi = special & rs_zero;

    assign inst_set.add   = r3 & (fn == `DEC_FN_ADD);
    assign inst_set.addu  = r3 & (fn == `DEC_FN_ADDU);
    assign inst_set.sub   = r3 & (fn == `DEC_FN_SUB);
    assign inst_set.subu  = r3 & (fn == `DEC_FN_SUBU);
    assign inst_set.slt   = r3 & (fn == `DEC_FN_SLT);
    assign inst_set.sltu  = r3 & (fn == `DEC_FN_SLTU);
    assign inst_set.and_r = r3 & (fn == `DEC_FN_AND);
    assign inst_set.nor_r = r3 & (fn == `DEC_FN_NOR);
    assign inst_set.or_r  = r3 & (fn == `DEC_FN_OR);
    assign inst_set.xor_r = r3 & (fn == `DEC_FN_XOR);
    assign inst_set.sllv  = r3 & (fn == `DEC_FN_SLLV);
    assign inst_set.srlv  = r3 & (fn == `DEC_FN_SRLV);
    assign inst_set.srav  = r3 & (fn == `DEC_FN_SRAV);
    assign inst_set.sll   = shi & (fn == `DEC_FN_SLL);
    assign inst_set.srl   = shi & (fn == `DEC_FN_SRL);
    assign inst_set.sra   = shi & (fn == `DEC_FN_SRA);

    assign inst_set.addi  = (inst.i.opcode == `DEC_OP_ADDI);
    assign inst_set.addiu = (inst.i.opcode == `DEC_OP_ADDIU);
    assign inst_set.slti  = (inst.i.opcode == `DEC_OP_SLTI);
    assign inst_set.sltiu = (inst.i.opcode == `DEC_OP_SLTIU);
    assign inst_set.andi  = (inst.i.opcode == `DEC_OP_ANDI);
    assign inst_set.ori   = (inst.i.opcode == `DEC_OP_ORI);
    assign inst_set.xori  = (inst.i.opcode == `DEC_OP_XORI);
    assign inst_set.lui   = (inst.i.opcode == `DEC_OP_LUI);

    assign inst_set.beq    = (inst.i.opcode == `DEC_OP_BEQ);
    assign inst_set.bne    = (inst.i.opcode == `DEC_OP_BNE);
    assign inst_set.bgtz   = (inst.i.opcode == `DEC_OP_BGTZ) & rt_zero;
    assign inst_set.blez   = (inst.i.opcode == `DEC_OP_BLEZ) & rt_zero;
    assign inst_set.bgez   = regimm & (inst.i.rt == `DEC_RT_BGEZ);
    assign inst_set.bltz   = regimm & (inst.i.rt == `DEC_RT_BLTZ);
    assign inst_set.bgezal = regimm & (inst.i.rt == `DEC_RT_BGEZAL);
    assign inst_set.bltzal = regimm & (inst.i.rt == `DEC_RT_BLTZAL);

    assign inst_set.j    = (inst.j.opcode == `DEC_OP_J);
    assign inst_set.jal  = (inst.j.opcode == `DEC_OP_JAL);
    assign inst_set.jr   = special & rt_zero & rd_zero & sa_zero & (fn == `DEC_FN_JR);
    assign inst_set.jalr = special & rt_zero & sa_zero & (fn == `DEC_FN_JALR);

    assign inst_set.lb  = (inst.i.opcode == `DEC_OP_LB);
    assign inst_set.lbu = (inst.i.opcode == `DEC_OP_LBU);
    assign inst_set.lh  = (inst.i.opcode == `DEC_OP_LH);
    assign inst_set.lhu = (inst.i.opcode == `DEC_OP_LHU);
    assign inst_set.lw  = (inst.i.opcode == `DEC_OP_LW);
    assign inst_set.sb  = (inst.i.opcode == `DEC_OP_SB);
    assign inst_set.sh  = (inst.i.opcode == `DEC_OP_SH);
    assign inst_set.sw  = (inst.i.opcode == `DEC_OP_SW);

    assign inst_set.syscall = special & (fn == `DEC_FN_SYSCALL);
    assign inst_set.brk     = special & (fn == `DEC_FN_BREAK);
    assign inst_set.eret    = cop0 & (fn == `DEC_FN_ERET);
    // sel lives in funct[2:0], the rest of funct must be zero
    assign inst_set.mfc0 = cop0 & (inst.r.rs == `DEC_RS_MFC0) & sa_zero & (fn[5:3] == 3'b000);
    assign inst_set.mtc0 = cop0 & (inst.r.rs == `DEC_RS_MTC0) & sa_zero & (fn[5:3] == 3'b000);

endmodule

// File: verilog/ctrl_gen.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module ctrl_gen import isa_pkg::*, ctrl_pkg::*; (
    input  inst_word_t inst,
    input  inst_set_t  inst_set,
    output id_ctrl_t   id_ctrl
);

    logic alu_r, shift_v, shift_i, imm_s, imm_z;
    logic load, store, link;
    logic dst_rd, dst_rt;

    assign alu_r = inst_set.add | inst_set.addu | inst_set.sub | inst_set.subu
                 | inst_set.slt | inst_set.sltu | inst_set.and_r | inst_set.nor_r
                 | inst_set.or_r | inst_set.xor_r;
    assign shift_v = inst_set.sllv | inst_set.srlv | inst_set.srav;
    assign shift_i = inst_set.sll | inst_set.srl | inst_set.sra;
    assign imm_s   = inst_set.addi | inst_set.addiu | inst_set.slti | inst_set.sltiu;
    assign imm_z   = inst_set.andi | inst_set.ori | inst_set.xori;
    assign load    = inst_set.lb | inst_set.lbu | inst_set.lh | inst_set.lhu | inst_set.lw;
    assign store   = inst_set.sb | inst_set.sh | inst_set.sw;
    // link value is pc + 8 computed in execute
    assign link    = inst_set.jal | inst_set.jalr | inst_set.bgezal | inst_set.bltzal;

    assign dst_rd = alu_r | shift_v | shift_i;
    assign dst_rt = imm_s | imm_z | inst_set.lui | load | inst_set.mfc0;

    always_comb begin
        id_ctrl.src1_sel.rs = alu_r | shift_v | imm_s | imm_z | load | store;
        id_ctrl.src1_sel.pc = link;
        id_ctrl.src1_sel.sa = shift_i;

        id_ctrl.src2_sel.rt   = alu_r | shift_v | shift_i | inst_set.mtc0;
        id_ctrl.src2_sel.simm = imm_s | inst_set.lui | load | store;
        id_ctrl.src2_sel.link = link;
        id_ctrl.src2_sel.zimm = imm_z;

        // address calc and mtc0 pass-through both use the adder
        id_ctrl.alu_op.op_add  = inst_set.add | inst_set.addu | inst_set.addi | inst_set.addiu
                               | link | load | store | inst_set.mtc0;
        id_ctrl.alu_op.op_sub  = inst_set.sub | inst_set.subu;
        id_ctrl.alu_op.op_slt  = inst_set.slt | inst_set.slti;
        id_ctrl.alu_op.op_sltu = inst_set.sltu | inst_set.sltiu;
        id_ctrl.alu_op.op_and  = inst_set.and_r | inst_set.andi;
        id_ctrl.alu_op.op_nor  = inst_set.nor_r;
        id_ctrl.alu_op.op_or   = inst_set.or_r | inst_set.ori;
        id_ctrl.alu_op.op_xor  = inst_set.xor_r | inst_set.xori;
        id_ctrl.alu_op.op_sll  = inst_set.sll | inst_set.sllv;
        id_ctrl.alu_op.op_srl  = inst_set.srl | inst_set.srlv;
        id_ctrl.alu_op.op_sra  = inst_set.sra | inst_set.srav;
        id_ctrl.alu_op.op_lui  = inst_set.lui;

        id_ctrl.mem_op = {inst_set.lb, inst_set.lbu, inst_set.lh, inst_set.lhu,
                          inst_set.lw, inst_set.sb, inst_set.sh, inst_set.sw};
        id_ctrl.mem_en       = load | store;
        id_ctrl.mem_wen      = store;
        id_ctrl.rf_from_load = load;

        id_ctrl.rf_we = dst_rd | dst_rt | link;
        if (dst_rd) begin
            id_ctrl.rf_waddr = inst.r.rd;
        end else if (dst_rt) begin
            id_ctrl.rf_waddr = inst.r.rt;
        end else if (link) begin
            id_ctrl.rf_waddr = `DEC_LINK_REG;
        end else begin
            id_ctrl.rf_waddr = '0;
        end
    end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module branch_unit import isa_pkg::*, ctrl_pkg::*; (
    input  logic [`DEC_WORD_W-1:0] id_pc,
    input  inst_word_t             inst,
    input  inst_set_t              inst_set,
    input  logic [`DEC_WORD_W-1:0] rs_data,
    input  logic [`DEC_WORD_W-1:0] rt_data,
    output br_bus_t                br_bus,
    output logic                   is_branch
);

    logic [`DEC_WORD_W-1:0] pc_plus_4;
    logic [`DEC_WORD_W-1:0] br_offset;
    logic eq, ge_z, gt_z, le_z, lt_z;
    logic cond_br, cond_ok, jump_idx, jump_reg;

    assign pc_plus_4 = id_pc + 32'd4;
    // word offset, sign extended
    assign br_offset = {{(`DEC_WORD_W-`DEC_IMM_W-2){inst.i.imm[`DEC_IMM_W-1]}},
                        inst.i.imm, 2'b00};

    assign eq   = (rs_data == rt_data);
    assign lt_z = rs_data[`DEC_WORD_W-1];
    assign ge_z = ~lt_z;
    assign le_z = lt_z | (rs_data == '0);
    assign gt_z = ~le_z;

    assign cond_br  = inst_set.beq | inst_set.bne | inst_set.bgez | inst_set.bgtz
                    | inst_set.blez | inst_set.bltz | inst_set.bgezal | inst_set.bltzal;
    assign cond_ok  = (inst_set.beq & eq) | (inst_set.bne & ~eq)
                    | ((inst_set.bgez | inst_set.bgezal) & ge_z) | (inst_set.bgtz & gt_z)
                    | (inst_set.blez & le_z) | ((inst_set.bltz | inst_set.bltzal) & lt_z);
    assign jump_idx = inst_set.j | inst_set.jal;
    assign jump_reg = inst_set.jr | inst_set.jalr;

    always_comb begin
        br_bus.br_taken = cond_ok | jump_idx | jump_reg;
        if (cond_br) begin
            br_bus.br_target = pc_plus_4 + br_offset;
        end else if (jump_idx) begin
            br_bus.br_target = {id_pc[31:28], inst.j.index, 2'b00};
        end else if (jump_reg) begin
            br_bus.br_target = rs_data;
        end else begin
            br_bus.br_target = '0;
        end
    end

    assign is_branch = cond_br | jump_idx | jump_reg;

endmodule

// File: verilog/except_hazard.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module except_hazard import isa_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ce,
    input  logic [`DEC_WORD_W-1:0] id_pc,
    input  inst_word_t             inst,
    input  inst_set_t              inst_set,
    input  logic                   is_branch,
    input  ex_fwd_t                ex_fwd,
    output except_t                except,
    output logic                   stall_load,
    output logic                   stall_cp0
);

    logic delay_slot_q;
    logic ex_hits_src;

    // next valid instruction sits in the delay slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            delay_slot_q <= 1'b0;
        end else if (ce) begin
            delay_slot_q <= is_branch;
        end
    end

    always_comb begin
        except.cp0_sel       = inst.r.rd;
        except.delay_slot    = delay_slot_q;
        except.pc_misaligned = |id_pc[1:0];
        except.syscall       = inst_set.syscall;
        except.brk           = inst_set.brk;
        except.invalid       = ce & ~(|inst_set);
        except.eret          = inst_set.eret;
        except.mfc0          = inst_set.mfc0;
        except.mtc0          = inst_set.mtc0;
    end

    assign stall_load = inst_set.lb | inst_set.lbu | inst_set.lh | inst_set.lhu | inst_set.lw;

    // cp0 read result is not forwardable from execute
    assign ex_hits_src = ex_fwd.rf_we
                       & ((ex_fwd.rf_waddr == inst.r.rs) | (ex_fwd.rf_waddr == inst.r.rt));
    assign stall_cp0   = ex_fwd.is_mfc0 & ex_hits_src;

    // rejected word must not redirect fetch either
    a_invalid_needs_ce: assert property (
        @(posedge clk) disable iff (!arst_n) except.invalid |-> ce && !is_branch);

    a_cp0_stall_src: assert property (
        @(posedge clk) disable iff (!arst_n) stall_cp0 |-> ex_fwd.is_mfc0);

    // delay slot only follows a decoded branch or jump
    a_delay_slot_rise: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(except.delay_slot) |-> $past(is_branch && ce));

endmodule

// File: verilog/id_decoder.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module id_decoder import isa_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ce,
    input  inst_word_t             inst,
    input  logic [`DEC_WORD_W-1:0] id_pc,
    input  logic [`DEC_WORD_W-1:0] rs_data,
    input  logic [`DEC_WORD_W-1:0] rt_data,
    input  ex_fwd_t                ex_fwd,
    output id_ctrl_t               id_ctrl,
    output br_bus_t                br_bus,
    output except_t                except,
    output logic                   stall_load,
    output logic                   stall_cp0
);

    inst_set_t inst_set;
    logic      is_branch;

    inst_match inst_match_i (
        .inst     (inst),
        .inst_set (inst_set)
    );

    ctrl_gen ctrl_gen_i (
        .inst     (inst),
        .inst_set (inst_set),
        .id_ctrl  (id_ctrl)
    );

    branch_unit branch_unit_i (
        .id_pc     (id_pc),
        .inst      (inst),
        .inst_set  (inst_set),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .br_bus    (br_bus),
        .is_branch (is_branch)
    );

    except_hazard except_hazard_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ce         (ce),
        .id_pc      (id_pc),
        .inst       (inst),
        .inst_set   (inst_set),
        .is_branch  (is_branch),
        .ex_fwd     (ex_fwd),
        .except     (except),
        .stall_load (stall_load),
        .stall_cp0  (stall_cp0)
    );

endmodule

// File: sim/tb_id_decoder.sv
`timescale 1ns/1ps
`include "decoder_defines.svh"

module tb_id_decoder
    import isa_pkg::*, ctrl_pkg::*;
();

    localparam int    FIELDS     = 11;
    localparam int    DEPTH      = 1024;
    localparam int    MAX_LINES  = DEPTH / FIELDS;
    localparam int    RST_CYCLES = 16;
    localparam string STIM_FILE  = "sim/id_stim.txt";

    logic                   clk;
    logic                   arst_n;
    logic                   ce;
    inst_word_t             inst;
    logic [`DEC_WORD_W-1:0] id_pc;
    logic [`DEC_WORD_W-1:0] rs_data;
    logic [`DEC_WORD_W-1:0] rt_data;
    ex_fwd_t                ex_fwd;
    id_ctrl_t               id_ctrl;
    br_bus_t                br_bus;
    except_t                except;
    logic                   stall_load;
    logic                   stall_cp0;

    logic [39:0] stim_mem [0:DEPTH-1];
    int          n_lines;
    int          ctrl_errs, br_errs, except_errs, stall_errs, other_errs;
    bit          limit_ready;

    id_decoder dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ce         (ce),
        .inst       (inst),
        .id_pc      (id_pc),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .ex_fwd     (ex_fwd),
        .id_ctrl    (id_ctrl),
        .br_bus     (br_bus),
        .except     (except),
        .stall_load (stall_load),
        .stall_cp0  (stall_cp0)
    );

    always #5 clk = ~clk;

    function automatic logic [39:0] stim_field(input int row, input int col);
        logic [9:0] addr;
        addr = 10'(row * FIELDS + col);
        return stim_mem[addr];
    endfunction

    task automatic check_ctrl(input string name, input id_ctrl_t exp, input id_ctrl_t act);
        if (act !== exp) begin
            ctrl_errs++;
            $display("ERR %s id_ctrl expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_br(input string name, input br_bus_t exp, input br_bus_t act);
        if (act !== exp) begin
            br_errs++;
            $display("ERR %s br_bus expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_except(input string name, input except_t exp, input except_t act);
        if (act !== exp) begin
            except_errs++;
            $display("ERR %s except expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stall_errs++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    // unused entries carry their own address, so any ce field above 1 ends the table
    task automatic load_stim();
        int fd;
        for (int k = 0; k < DEPTH; k++) begin
            stim_mem[10'(k)] = {8'hee, 32'(k)};
        end
        n_lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("stimulus file %s could not be opened", STIM_FILE);
        end else begin
            $fclose(fd);
            $readmemh(STIM_FILE, stim_mem);
            while (n_lines < MAX_LINES && stim_field(n_lines, 0) <= 40'd1) begin
                n_lines++;
            end
            if (n_lines == 0) begin
                other_errs++;
                $display("stimulus file %s holds no test lines", STIM_FILE);
            end
        end
    endtask

    task automatic apply_line(input int row);
        logic [39:0] f_ce, f_pc, f_inst, f_rs, f_rt, f_fwd;
        f_ce   = stim_field(row, 0);
        f_pc   = stim_field(row, 1);
        f_inst = stim_field(row, 2);
        f_rs   = stim_field(row, 3);
        f_rt   = stim_field(row, 4);
        f_fwd  = stim_field(row, 5);
        ce      <= f_ce[0];
        id_pc   <= f_pc[31:0];
        inst    <= f_inst[31:0];
        rs_data <= f_rs[31:0];
        rt_data <= f_rt[31:0];
        ex_fwd  <= f_fwd[$bits(ex_fwd_t)-1:0];
    endtask

    task automatic check_line(input int row);
        logic [39:0] f_ctrl, f_br, f_exc, f_sl, f_sc;
        string       name;
        f_ctrl = stim_field(row, 6);
        f_br   = stim_field(row, 7);
        f_exc  = stim_field(row, 8);
        f_sl   = stim_field(row, 9);
        f_sc   = stim_field(row, 10);
        name   = $sformatf("line %0d", row);
        check_ctrl(name, f_ctrl[$bits(id_ctrl_t)-1:0], id_ctrl);
        check_br(name, f_br[$bits(br_bus_t)-1:0], br_bus);
        check_except(name, f_exc[$bits(except_t)-1:0], except);
        check_stall({name, " stall_load"}, f_sl[0], stall_load);
        check_stall({name, " stall_cp0"}, f_sc[0], stall_cp0);
    endtask

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b1;
        ce      = 1'b0;
        inst    = '0;
        id_pc   = '0;
        rs_data = '0;
        rt_data = '0;
        ex_fwd  = '0;
        load_stim();
        limit_ready = 1'b1;
        // falling edge on reset just after time zero
        #1 arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            apply_line(i);
            @(negedge clk);
            check_line(i);
        end
        @(posedge clk);
        $display("errors ctrl=%0d br=%0d except=%0d stall=%0d other=%0d",
                 ctrl_errs, br_errs, except_errs, stall_errs, other_errs);
        if (ctrl_errs + br_errs + except_errs + stall_errs + other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        #((n_lines + RST_CYCLES + 10) * 10);
        $display("watchdog expired after %0d cycles with lines still pending",
                 n_lines + RST_CYCLES + 10);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: id_decoder.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/inst_match.sv
verilog/ctrl_gen.sv
verilog/branch_unit.sv
verilog/except_hazard.sv
verilog/id_decoder.sv
sim/tb_id_decoder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_decoder
FILELIST  ?= id_decoder.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

PASS_MSG := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS: $(TOP)" || \
		{ echo "FAIL: $(TOP), see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/id_stim.txt
// ce id_pc inst rs_data rt_data ex_fwd | id_ctrl br_bus except stall_load stall_cp0
// all hex, one line per clock
1 bfc00000 00221820 00000005 00000007 00 800220046 000000000 0300 0 0
1 bfc00004 00a62022 00000000 00000000 00 400220048 000000000 0400 0 0
1 bfc00008 0109382a 00000000 00000000 00 20022004e 000000000 0700 0 0
1 bfc0000c 016c5027 00000000 00000000 00 040220054 000000000 0a00 0 0
1 bfc00010 00031100 00000000 00000000 00 008820044 000000000 0200 0 0
1 bfc00014 00e62807 00000000 00000000 00 00222004a 000000000 0500 0 0
1 bfc00018 2509fffc 00000000 00000000 00 800240052 000000000 1f00 0 0
1 bfc0001c 34041234 00000000 00000000 00 020300048 000000000 0200 0 0
1 bfc00020 3c06abcd 00000000 00000000 00 00104004c 000000000 1500 0 0
// loads and stores
1 bfc00024 8fa80010 00000000 00000000 00 800241151 000000000 0000 1 0
1 bfc00028 8089ffff 00000000 00000000 00 800250153 000000000 1f00 1 0
1 bfc0002c 94620002 00000000 00000000 00 800242145 000000000 0000 1 0
1 bfc00030 afa70008 00000000 00000000 00 800240380 000000000 0000 0 0
1 bfc00034 a4450006 00000000 00000000 00 800240580 000000000 0000 0 0
// branches and jumps, delay slot follows each one
1 bfc00100 10220010 12345678 12345678 00 000000000 1bfc00144 0000 0 0
1 bfc00104 1422fffc 12345678 12345678 00 000000000 0bfc000f8 1f80 0 0
1 bfc00108 08000100 00000000 00000000 00 000000000 1b0000400 0080 0 0
1 bfc0010c 0c123456 00000000 00000000 00 80048007e 1b048d158 0680 0 0
1 bfc00110 03e00008 80001234 00000000 00 000000000 180001234 0080 0 0
1 bfc00114 00a02009 00400010 00000000 00 80048007e 100400010 0480 0 0
// mult with ce low, then mflo with ce high
0 bfc00118 00850018 00000000 00000000 00 000000000 000000000 0080 0 0
1 bfc00118 00004012 00000000 00000000 00 000000000 000000000 0888 0 0
1 bfc0011c 0000000c 00000000 00000000 00 000000000 000000000 0020 0 0
1 bfc00120 0000000d 00000000 00000000 00 000000000 000000000 0010 0 0
1 bfc00124 42000018 00000000 00000000 00 000000000 000000000 0004 0 0
1 bfc00128 40086000 00000000 00000000 00 000000050 000000000 0c02 0 0
1 bfc0012c 40897000 00000000 00000000 00 800020000 000000000 0e01 0 0
1 bfc00202 00221821 00000000 00000000 00 800220046 000000000 0340 0 0
// cp0 hazard hits and near misses
1 bfc00204 00221821 00000000 00000000 43 800220046 000000000 0300 0 1
1 bfc00208 00221821 00000000 00000000 45 800220046 000000000 0300 0 1
1 bfc0020c 00221821 00000000 00000000 05 800220046 000000000 0300 0 0
1 bfc00210 00221821 00000000 00000000 42 800220046 000000000 0300 0 0
1 bfc00214 00221821 00000000 00000000 47 800220046 000000000 0300 0 0
1 bfc00300 04910004 00000000 00000000 00 80048007e 1bfc00314 0000 0 0
1 bfc00304 04800002 00000001 00000000 00 000000000 0bfc00310 0080 0 0
1 bfc00308 1c800001 00000005 00000000 00 000000000 1bfc00310 0080 0 0
1 bfc0030c 18800001 00000005 00000000 00 000000000 0bfc00314 0080 0 0
1 bfc00310 00000000 00000000 00000000 00 008820040 000000000 0080 0 0
